// File: src.f
logic/gf2m_pkg.sv
logic/clmul_serial.sv
logic/karatsuba_mul.sv
logic/gf2m_reduce.sv
logic/wb_gf2m_regs.sv
logic/gf2m_accel_top.sv
dv/clk_gen.sv
dv/gf2m_accel_props.sv
dv/tb_gf2m_accel.sv

// File: Bender.yml
package:
  name: gf2m_accel

sources:
  - files:
      - logic/gf2m_pkg.sv
      - logic/clmul_serial.sv
      - logic/karatsuba_mul.sv
      - logic/gf2m_reduce.sv
      - logic/wb_gf2m_regs.sv
      - logic/gf2m_accel_top.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/gf2m_accel_props.sv
      - dv/tb_gf2m_accel.sv

// File: dv/tb_gf2m_accel.sv
// ============================
// Testbench for the GF(2^163)
// Wishbone multiplier accelerator
// ============================
`timescale 1ns/1ns

module tb_gf2m_accel
	import gf2m_pkg::*;
();

	localparam int cmp_w = op_words * wb_dw;
	localparam int ack_limit = 16;
	localparam int poll_limit = 200;

	logic             clk;
	logic             rst;
	logic             cyc;
	logic             stb;
	logic             we;
	logic [wb_aw-1:0] adr;
	logic [wb_dw-1:0] dat_w;
	logic [wb_dw-1:0] dat_r;
	logic             ack;
	integer           seed;
	int               errors;
	logic [cmp_w-1:0] exp_q[$];
	logic [cmp_w-1:0] got_q[$];
	string            name_q[$];

	clk_gen #(.period(8), .rst_cycles(3)) u_clk (.clk(clk), .rst(rst));

	gf2m_accel_top uut (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack)
	);

	bind gf2m_accel_top gf2m_accel_props u_props (
		.clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack),
		.start(start), .busy(u_regs.busy), .done(u_regs.done)
	);

	// MSB first shift-and-xor, x^163 folded onto the taps at every step
	function automatic logic [gf_m-1:0] field_mul(input logic [gf_m-1:0] a,
			input logic [gf_m-1:0] b);
		logic [gf_m:0] acc;
		acc = '0;
		for (int i = gf_m - 1; i >= 0; i--) begin
			acc = acc << 1;
			if (acc[gf_m]) begin
				acc[gf_m] = 1'b0;
				acc[7:0] = acc[7:0] ^ red_taps;
			end
			if (b[i]) begin
				acc[gf_m-1:0] = acc[gf_m-1:0] ^ a;
			end
		end
		return acc[gf_m-1:0];
	endfunction

	function automatic logic [gf_m-1:0] rand_elem();
		logic [cmp_w-1:0] v;
		for (int i = 0; i < op_words; i++) begin
			v[i*wb_dw +: wb_dw] = $random(seed);
		end
		return v[gf_m-1:0];
	endfunction

	task automatic abort_run(input string why);
		$display("%s at %0t", why, $time);
		$display("Checks stopped, %0d errors", errors);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic check_value(input logic [cmp_w-1:0] got, input logic [cmp_w-1:0] exp,
			input string msg);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s, got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	// Classic cycle, held until one cycle after ack is seen
	task automatic wb_cycle(input logic w, input logic [wb_aw-1:0] a,
			input logic [wb_dw-1:0] d, output logic [wb_dw-1:0] q);
		int n;
		cyc = 1'b1;
		stb = 1'b1;
		we = w;
		adr = a;
		dat_w = d;
		n = 0;
		while (!ack && n < ack_limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!ack) begin
			abort_run("No bus ack received");
		end else begin
			q = dat_r;
			@(posedge clk);
			#1;
			cyc = 1'b0;
			stb = 1'b0;
			we = 1'b0;
		end
	endtask

	task automatic wb_write(input logic [wb_aw-1:0] a, input logic [wb_dw-1:0] d);
		logic [wb_dw-1:0] unused;
		wb_cycle(1'b1, a, d, unused);
	endtask

	task automatic wb_read(input logic [wb_aw-1:0] a, output logic [wb_dw-1:0] q);
		wb_cycle(1'b0, a, '0, q);
	endtask

	task automatic load_operands(input logic [gf_m-1:0] a, input logic [gf_m-1:0] b);
		logic [cmp_w-1:0] ea;
		logic [cmp_w-1:0] eb;
		ea = cmp_w'(a);
		eb = cmp_w'(b);
		for (int i = 0; i < op_words; i++) begin
			wb_write(wb_aw'(addr_a + i), ea[i*wb_dw +: wb_dw]);
			wb_write(wb_aw'(addr_b + i), eb[i*wb_dw +: wb_dw]);
		end
	endtask

	task automatic wait_done();
		logic [wb_dw-1:0] s;
		int n;
		s = '0;
		n = 0;
		while (!s[stat_done] && n < poll_limit) begin
			wb_read(addr_status, s);
			n++;
		end
		if (!s[stat_done]) abort_run("Multiplication never reported done");
	endtask

	// Reads the six result words and queues them with the expected value
	task automatic collect_result(input logic [gf_m-1:0] a, input logic [gf_m-1:0] b,
			input string label);
		logic [cmp_w-1:0] r;
		logic [wb_dw-1:0] w;
		for (int i = 0; i < op_words; i++) begin
			wb_read(wb_aw'(addr_res + i), w);
			r[i*wb_dw +: wb_dw] = w;
		end
		exp_q.push_back(cmp_w'(field_mul(a, b)));
		got_q.push_back(r);
		name_q.push_back(label);
	endtask

	task automatic run_mult(input logic [gf_m-1:0] a, input logic [gf_m-1:0] b,
			input string label);
		load_operands(a, b);
		wb_write(addr_ctrl, 32'h1);
		wait_done();
		collect_result(a, b, label);
	endtask

	always @(posedge clk) begin
		if (got_q.size() != 0) begin
			check_value(got_q.pop_front(), exp_q.pop_front(), name_q.pop_front());
		end
	end

	initial begin
		logic [gf_m-1:0]  a;
		logic [gf_m-1:0]  b;
		logic [gf_m-1:0]  x162;
		logic [wb_dw-1:0] w;
		int               n;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		errors = 0;
		seed = 32'hd0c92509;
		n = 0;
		while (rst !== 1'b0 && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (rst !== 1'b0) abort_run("Reset was never released");

		// Idle state after reset
		wb_read(addr_status, w);
		check_value(cmp_w'(w), '0, "status after reset");
		for (int i = 0; i < op_words; i++) begin
			wb_read(wb_aw'(addr_res + i), w);
			check_value(cmp_w'(w), '0, $sformatf("result word %0d after reset", i));
		end

		// Identities and the double reduction case
		a = rand_elem();
		b = rand_elem();
		x162 = '0;
		x162[gf_m-1] = 1'b1;
		run_mult(gf_m'(1), b, "1 x B");
		run_mult(a, gf_m'(1), "A x 1");
		run_mult(x162, x162, "x^162 x x^162");

		for (int i = 0; i < 50; i++) begin
			a = rand_elem();
			b = rand_elem();
			run_mult(a, b, $sformatf("random pair %0d", i));
		end

		// New operands and a second start during a run change nothing
		a = rand_elem();
		b = rand_elem();
		load_operands(a, b);
		wb_write(addr_ctrl, 32'h1);
		load_operands(rand_elem(), rand_elem());
		wb_write(addr_ctrl, 32'h1);
		wb_read(addr_status, w);
		check_value(cmp_w'(w), cmp_w'(1), "status while busy");
		wait_done();
		collect_result(a, b, "writes while busy");

		// Read requested on cycle 83, then on cycle 84, after the start ack
		wb_write(addr_ctrl, 32'h1);
		repeat (82) begin
			@(posedge clk);
			#1;
		end
		wb_read(addr_status, w);
		check_value(cmp_w'(w), cmp_w'(1), "status one cycle before done");
		wait_done();
		wb_write(addr_ctrl, 32'h1);
		repeat (83) begin
			@(posedge clk);
			#1;
		end
		wb_read(addr_status, w);
		check_value(cmp_w'(w), cmp_w'(2), "status on the done cycle");
		collect_result(a, b, "repeat run");

		n = 0;
		while (got_q.size() != 0 && n < 10) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (got_q.size() != 0) begin
			abort_run("Result queue was not drained");
		end else begin
			$display("Checks done, %0d errors", errors);
			if (errors == 0) begin
				$display("SIMULATION PASSED");
			end else begin
				$display("SIMULATION FAILED");
			end
			$finish;
		end
	end

endmodule

// File: dv/gf2m_accel_props.sv
// ============================
// Bus handshake and status checks
// for the GF(2^163) accelerator
// ============================
`timescale 1ns/1ns

module gf2m_accel_props
	import gf2m_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic start,
	input logic busy,
	input logic done
);

	// Serial units, combine register and reduce register
	localparam int done_lat = half_lo + 2;

	ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
		else $error("ack stayed high for more than one cycle");

	ack_after_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(cyc && stb))
		else $error("ack rose without a preceding cyc and stb");

	flags_apart: assert property (@(posedge clk) disable iff (rst) !(busy && done))
		else $error("busy and done high together");

	done_latency: assert property (@(posedge clk) disable iff (rst)
		start |-> ##done_lat $rose(done))
		else $error("done did not rise at the expected cycle after start");

endmodule

// File: dv/clk_gen.sv
// ============================
// Testbench clock and reset
// ============================
`timescale 1ns/1ns

module clk_gen #(
	parameter int period = 8,
	parameter int rst_cycles = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Release lands with the stimulus delay
	initial begin
		rst = 1'b1;
		repeat (rst_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
	end

endmodule

// File: logic/gf2m_accel_top.sv
// ============================
// GF(2^163) multiplier accelerator
// Wishbone slave, Karatsuba core
// and B-163 reduction
// ============================
`timescale 1ns/1ns

module gf2m_accel_top
	import gf2m_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  logic [wb_aw-1:0] adr,
	input  logic [wb_dw-1:0] dat_w,
	output logic [wb_dw-1:0] dat_r,
	output logic             ack
);

	logic [gf_m-1:0]   op_a;
	logic [gf_m-1:0]   op_b;
	logic              start;
	logic [prod_w-1:0] prod;
	logic              prod_valid;
	logic [gf_m-1:0]   res;
	logic              res_valid;

	wb_gf2m_regs u_regs (
		.clk(clk), .rst(rst),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .dat_r(dat_r), .ack(ack),
		.op_a(op_a), .op_b(op_b), .start(start),
		.res(res), .res_valid(res_valid)
	);

	karatsuba_mul #(.M(gf_m)) u_mul (
		.clk(clk), .rst(rst), .start(start),
		.op_a(op_a), .op_b(op_b),
		.prod(prod), .prod_valid(prod_valid)
	);

	gf2m_reduce u_red (
		.clk(clk), .rst(rst),
		.prod(prod), .prod_valid(prod_valid),
		.res(res), .res_valid(res_valid)
	);

endmodule

// File: logic/wb_gf2m_regs.sv
// ============================
// Wishbone register block
// Operands, start, status flags
// and result readback
// ============================
`timescale 1ns/1ns

module wb_gf2m_regs
	import gf2m_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  logic [wb_aw-1:0] adr,
	input  logic [wb_dw-1:0] dat_w,
	output logic [wb_dw-1:0] dat_r,
	output logic             ack,
	output logic [gf_m-1:0]  op_a,
	output logic [gf_m-1:0]  op_b,
	output logic             start,
	input  logic [gf_m-1:0]  res,
	input  logic             res_valid
);

	localparam int op_bits = op_words * wb_dw;
	localparam int idx_w = $clog2(op_words);

	logic [op_bits-1:0] a_words;
	logic [op_bits-1:0] b_words;
	logic [gf_m-1:0]    res_q;
	logic [op_bits-1:0] res_ext;
	logic               busy_q;
	logic               done_q;
	logic               busy;
	logic               done;
	logic               wr_cyc;
	logic               sel_a;
	logic               sel_b;
	logic               sel_ctrl;
	logic               sel_status;
	logic               sel_res;
	logic [idx_w-1:0]   a_idx;
	logic [idx_w-1:0]   b_idx;
	logic [idx_w-1:0]   r_idx;
	logic [wb_dw-1:0]   rd_data;

	// Address decode
	assign sel_a = (adr >= addr_a) && (adr < addr_a + op_words);
	assign sel_b = (adr >= addr_b) && (adr < addr_b + op_words);
	assign sel_res = (adr >= addr_res) && (adr < addr_res + op_words);
	assign sel_ctrl = (adr == addr_ctrl);
	assign sel_status = (adr == addr_status);
	assign a_idx = idx_w'(adr - addr_a);
	assign b_idx = idx_w'(adr - addr_b);
	assign r_idx = idx_w'(adr - addr_res);

	// Writes land on the ack cycle
	assign wr_cyc = ack & we;
	assign start = wr_cyc & sel_ctrl & dat_w[ctrl_start] & ~busy_q;

	// Single-cycle ack, read data registered with it
	always_ff @(posedge clk) begin
		if (rst) begin
			ack   <= 1'b0;
			dat_r <= '0;
		end else begin
			ack <= cyc & stb & ~ack;
			if (cyc && stb && !ack) begin
				dat_r <= rd_data;
			end
		end
	end

	// Operands are frozen while a multiplication runs
	always_ff @(posedge clk) begin
		if (wr_cyc && !busy_q) begin
			if (sel_a) begin
				a_words[a_idx*wb_dw +: wb_dw] <= dat_w;
			end
			if (sel_b) begin
				b_words[b_idx*wb_dw +: wb_dw] <= dat_w;
			end
		end
	end

	assign op_a = a_words[gf_m-1:0];
	assign op_b = b_words[gf_m-1:0];

	// Flags and result capture
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			res_q  <= '0;
		end else if (start) begin
			busy_q <= 1'b1;
			done_q <= 1'b0;
		end else if (res_valid) begin
			busy_q <= 1'b0;
			done_q <= 1'b1;
			res_q  <= res;
		end
	end

	// Status shows completion in the res_valid cycle itself
	assign busy = busy_q & ~res_valid;
	assign done = done_q | res_valid;

	assign res_ext = op_bits'(res_q);

	// Read mux, operand and control words read as zero
	always_comb begin
		rd_data = '0;
		if (sel_status) begin
			rd_data[stat_busy] = busy;
			rd_data[stat_done] = done;
		end else if (sel_res) begin
			rd_data = res_ext[r_idx*wb_dw +: wb_dw];
		end
	end

endmodule

// File: logic/gf2m_reduce.sv
// ============================
// B-163 reduction
// Two folding passes, registered
// ============================
`timescale 1ns/1ns

module gf2m_reduce
	import gf2m_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [prod_w-1:0] prod,
	input  logic              prod_valid,
	output logic [gf_m-1:0]   res,
	output logic              res_valid
);

	localparam int hi_w = prod_w - gf_m;
	localparam int tap_w = $bits(red_taps);
	localparam int f1_w = hi_w + tap_w - 1;
	localparam int f2_w = f1_w - gf_m;

	logic [hi_w-1:0] over1;
	logic [f1_w-1:0] fold1;
	logic [f2_w-1:0] over2;
	logic [gf_m-1:0] fold2;

	// First pass, x^163 replaced by the tap terms
	assign over1 = prod[prod_w-1:gf_m];

	always_comb begin
		fold1 = f1_w'(prod[gf_m-1:0]);
		for (int j = 0; j < tap_w; j++) begin
			if (red_taps[j]) begin
				fold1 = fold1 ^ (f1_w'(over1) << j);
			end
		end
	end

	// Second pass for the few bits pushed past 162
	assign over2 = fold1[f1_w-1:gf_m];

	always_comb begin
		fold2 = fold1[gf_m-1:0];
		for (int j = 0; j < tap_w; j++) begin
			if (red_taps[j]) begin
				fold2 = fold2 ^ (gf_m'(over2) << j);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			res <= fold2;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= prod_valid;
		end
	end

endmodule

// File: logic/karatsuba_mul.sv
// ============================
// Two-way Karatsuba multiplier
// Three serial units in parallel,
// combined into the full product
// ============================
`timescale 1ns/1ns

module karatsuba_mul #(
	parameter int M = 163
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           start,
	input  logic [M-1:0]   op_a,
	input  logic [M-1:0]   op_b,
	output logic [2*M-2:0] prod,
	output logic           prod_valid
);

	localparam int lo_w = (M + 1) / 2;
	localparam int hi_w = M - lo_w;
	localparam int lp_w = 2 * lo_w - 1;
	localparam int pw = 2 * M - 1;

	logic [lo_w-1:0]     a_lo;
	logic [lo_w-1:0]     b_lo;
	logic [hi_w-1:0]     a_hi;
	logic [hi_w-1:0]     b_hi;
	logic [lo_w-1:0]     a_sum;
	logic [lo_w-1:0]     b_sum;
	logic [lp_w-1:0]     p_lo;
	logic [2*hi_w-2:0]   p_hi;
	logic [lp_w-1:0]     p_sum;
	logic [lp_w-1:0]     p_mid;
	logic                lo_done;

	// Operand split, every bit kept
	assign a_lo = op_a[lo_w-1:0];
	assign b_lo = op_b[lo_w-1:0];
	assign a_hi = op_a[M-1:lo_w];
	assign b_hi = op_b[M-1:lo_w];
	assign a_sum = a_lo ^ lo_w'(a_hi);
	assign b_sum = b_lo ^ lo_w'(b_hi);

	clmul_serial #(.W(lo_w)) u_lo (
		.clk(clk), .rst(rst), .start(start),
		.x(a_lo), .y(b_lo), .p(p_lo), .done(lo_done)
	);

	// Shorter unit, finished before the low one
	clmul_serial #(.W(hi_w)) u_hi (
		.clk(clk), .rst(rst), .start(start),
		.x(a_hi), .y(b_hi), .p(p_hi), .done()
	);

	// Same length as the low unit, completes with it
	clmul_serial #(.W(lo_w)) u_sum (
		.clk(clk), .rst(rst), .start(start),
		.x(a_sum), .y(b_sum), .p(p_sum), .done()
	);

	// Middle term, subtraction is XOR in GF(2)
	assign p_mid = p_sum ^ p_lo ^ lp_w'(p_hi);

	always_ff @(posedge clk) begin
		if (lo_done) begin
			prod <= (pw'(p_hi) << (2 * lo_w)) ^ (pw'(p_mid) << lo_w) ^ pw'(p_lo);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= lo_done;
		end
	end

endmodule

// File: logic/clmul_serial.sv
// ============================
// Bit-serial carry-less multiplier
// One bit of x per cycle, done
// W cycles after start
// ============================
`timescale 1ns/1ns

module clmul_serial #(
	parameter int W = 82
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           start,
	input  logic [W-1:0]   x,
	input  logic [W-1:0]   y,
	output logic [2*W-2:0] p,
	output logic           done
);

	localparam int pw = 2 * W - 1;
	localparam int cnt_w = $clog2(W + 1);

	logic [W-1:0]     xr;
	logic [W-1:0]     yr;
	logic [cnt_w-1:0] cnt;
	logic             run;

	// Sequencing, counter runs 1 .. W
	always_ff @(posedge clk) begin
		if (rst) begin
			run  <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				run <= 1'b1;
				cnt <= cnt_w'(1);
			end else if (run) begin
				cnt <= cnt + 1'b1;
				if (cnt == cnt_w'(W - 1)) begin
					run  <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Accumulator, bit 0 is folded in while latching
	always_ff @(posedge clk) begin
		if (start) begin
			xr <= x;
			yr <= y;
			p  <= x[0] ? pw'(y) : '0;
		end else if (run && xr[cnt]) begin
			p <= p ^ (pw'(yr) << cnt);
		end
	end

endmodule

// File: logic/gf2m_pkg.sv
// ============================
// GF(2^163) multiplier constants
// Field sizes, reduction taps and
// the Wishbone register map
// ============================
package gf2m_pkg;

	// Field degree and unreduced product width
	localparam int gf_m = 163;
	localparam int prod_w = 2 * gf_m - 1;

	// Karatsuba halves, low half takes the odd bit
	localparam int half_lo = (gf_m + 1) / 2;
	localparam int half_hi = gf_m - half_lo;

	// Low-order terms of x^163 + x^7 + x^6 + x^3 + 1
	localparam logic [7:0] red_taps = 8'b1100_1001;

	// Bus geometry
	localparam int wb_dw = 32;
	localparam int wb_aw = 5;
	localparam int op_words = (gf_m + wb_dw - 1) / wb_dw;

	// Word addresses
	localparam logic [wb_aw-1:0] addr_a = 5'd0;
	localparam logic [wb_aw-1:0] addr_b = 5'd6;
	localparam logic [wb_aw-1:0] addr_ctrl = 5'd12;
	localparam logic [wb_aw-1:0] addr_status = 5'd13;
	localparam logic [wb_aw-1:0] addr_res = 5'd16;

	// Control and status bits
	localparam int ctrl_start = 0;
	localparam int stat_busy = 0;
	localparam int stat_done = 1;

endpackage
